//--- src/usb_stream_defines.svh
`ifndef USB_STREAM_DEFINES_SVH
`define USB_STREAM_DEFINES_SVH

// --------------------------------------------------
// bus and pixel widths
// --------------------------------------------------
`define USB_WORD_W      32
`define USB_PIX_W       16

// --------------------------------------------------
// packet format
// --------------------------------------------------
`define USB_PKT_WORDS   13'd4096        // full packet incl header
`define USB_HDR_WORDS   2'd3
`define USB_HDR_NORMAL  32'h0000_8C0C
`define USB_HDR_EOF     32'h0000_8E0C   // end of frame bit set
`define USB_GAP_CYCLES  4'd8            // idle cycles after a packet

// buffering and run time inputs
`define USB_FIFO_AW     10
`define USB_CNT_W       16

`endif

//--- src/usb_stream_pkg.sv
`include "usb_stream_defines.svh"

package usb_stream_pkg;

	typedef logic [`USB_WORD_W-1:0] usb_word_t;
	typedef logic [`USB_PIX_W-1:0]  pix_t;
	typedef logic [`USB_CNT_W-1:0]  cnt_t;

	// word counter wide enough to hold a full packet length
	localparam int WCNT_W = $clog2(`USB_PKT_WORDS + 1);
	typedef logic [WCNT_W-1:0] wcnt_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT_READY,
		ST_HEADER,
		ST_PAYLOAD,
		ST_GAP
	} master_state_t;

endpackage

//--- src/pixel_packer.sv
`include "usb_stream_defines.svh"

module pixel_packer
	import usb_stream_pkg::*;
(
	input  logic      hdmit_halfclk,
	input  logic      reset,
	input  logic      pix_de_i,
	input  pix_t      pix_data_i,
	input  logic      fifo_full_i,
	input  logic      fifo_afull_i,
	output logic      pix_ready_o,
	output logic      wr_en_o,
	output usb_word_t wr_data_o
);

	logic half_valid;   // first pixel of a pair is held
	pix_t half_q;
	logic accept;

	// hold off the source before the fifo can overflow
	assign pix_ready_o = ~(fifo_full_i | (fifo_afull_i & half_valid));
	assign accept      = pix_de_i & pix_ready_o;

	assign wr_en_o   = accept & half_valid;
	assign wr_data_o = {pix_data_i, half_q};   // first pixel in the low half

	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			half_valid <= 1'b0;
		end
		else if (accept)
		begin
			half_valid <= ~half_valid;
		end
	end

	always_ff @(posedge hdmit_halfclk)
	begin
		if (accept & ~half_valid)
		begin
			half_q <= pix_data_i;
		end
	end

endmodule

//--- src/stream_fifo.sv
`include "usb_stream_defines.svh"

module stream_fifo #(
	parameter int AW = `USB_FIFO_AW
) (
	input  logic                   hdmit_halfclk,
	input  logic                   reset,
	input  logic                   wr_en_i,
	input  logic [`USB_WORD_W-1:0] wr_data_i,
	input  logic                   rd_en_i,
	output logic [`USB_WORD_W-1:0] rd_data_o,
	output logic                   empty_o,
	output logic                   full_o,
	output logic                   afull_o
);

	localparam int DEPTH = 2 ** AW;

	logic [`USB_WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0]          wr_ptr;
	logic [AW-1:0]          rd_ptr;
	logic [AW:0]            count;
	logic                   do_wr;
	logic                   do_rd;

	assign do_wr = wr_en_i & ~full_o;
	assign do_rd = rd_en_i & ~empty_o;

	assign empty_o = (count == '0);
	assign full_o  = (count == (AW+1)'(DEPTH));
	assign afull_o = (count == (AW+1)'(DEPTH - 1));   // one slot left

	// head word falls through without a read cycle
	assign rd_data_o = mem[rd_ptr];

	always_ff @(posedge hdmit_halfclk)
	begin
		if (do_wr)
		begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
		end
	end

endmodule

//--- src/packet_counter.sv
`include "usb_stream_defines.svh"

module packet_counter
	import usb_stream_pkg::*;
(
	input  logic       hdmit_halfclk,
	input  logic       reset,
	input  logic       word_issue_i,
	input  logic       gap_run_i,
	input  cnt_t       pkt_count_i,
	input  cnt_t       last_words_i,
	output logic       hdr_done_o,
	output logic       pkt_last_o,
	output logic       frame_last_pkt_o,
	output logic       gap_done_o,
	output logic [1:0] hdr_idx_o
);

	wcnt_t      word_cnt;    // words issued in this packet
	cnt_t       pkt_idx;     // packet index within the frame
	wcnt_t      pkt_limit;
	logic [3:0] gap_cnt;

	// --------------------------------------------------
	// end flags
	// --------------------------------------------------
	assign frame_last_pkt_o = (pkt_idx == pkt_count_i - cnt_t'(1));
	assign pkt_limit = frame_last_pkt_o ? last_words_i[WCNT_W-1:0] : `USB_PKT_WORDS;

	assign hdr_idx_o  = word_cnt[1:0];
	assign hdr_done_o = (word_cnt == wcnt_t'(`USB_HDR_WORDS - 2'd1));   // last header word
	assign pkt_last_o = (word_cnt == pkt_limit - wcnt_t'(1));
	assign gap_done_o = (gap_cnt == `USB_GAP_CYCLES - 4'd1);

	// --------------------------------------------------
	// word and packet counters
	// --------------------------------------------------
	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			word_cnt <= '0;
			pkt_idx  <= '0;
		end
		else if (word_issue_i)
		begin
			if (pkt_last_o)
			begin
				word_cnt <= '0;
				// wrap at frame end
				pkt_idx  <= frame_last_pkt_o ? '0 : pkt_idx + cnt_t'(1);
			end
			else
			begin
				word_cnt <= word_cnt + wcnt_t'(1);
			end
		end
	end

	// gap timer, restarts every time the gap is entered
	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			gap_cnt <= '0;
		end
		else if (gap_run_i)
		begin
			gap_cnt <= gap_cnt + 4'd1;
		end
		else
		begin
			gap_cnt <= '0;
		end
	end

endmodule

//--- src/usb_master_fsm.sv
`include "usb_stream_defines.svh"

module usb_master_fsm
	import usb_stream_pkg::*;
(
	input  logic       hdmit_halfclk,
	input  logic       reset,
	input  logic       flaga_i,
	input  logic       fifo_empty_i,
	input  logic       hdr_done_i,
	input  logic       pkt_last_i,
	input  logic       gap_done_i,
	output logic       word_issue_o,
	output logic       hdr_sel_o,
	output logic       pop_o,
	output logic       gap_run_o,
	output logic [1:0] faddr_o
);

	master_state_t state;
	master_state_t state_nxt;
	logic          pkt_end_q;   // last word of a packet is on the bus

	// --------------------------------------------------
	// word issue strobes
	// --------------------------------------------------
	assign hdr_sel_o    = (state == ST_HEADER) & flaga_i;
	assign pop_o        = (state == ST_PAYLOAD) & flaga_i & ~fifo_empty_i;
	assign word_issue_o = hdr_sel_o | pop_o;
	assign gap_run_o    = (state == ST_GAP);

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				if (~fifo_empty_i)
					state_nxt = ST_WAIT_READY;
			end
			ST_WAIT_READY:
			begin
				if (flaga_i)
					state_nxt = ST_HEADER;
			end
			ST_HEADER:
			begin
				if (hdr_sel_o & hdr_done_i)
					state_nxt = ST_PAYLOAD;
			end
			ST_PAYLOAD:
			begin
				if (pop_o & pkt_last_i)
					state_nxt = ST_GAP;
			end
			ST_GAP:
			begin
				if (gap_done_i)
					state_nxt = ST_IDLE;
			end
			default:
			begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			state <= state_nxt;
		end
	end

	// socket flips once the last word of a packet has gone out
	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			pkt_end_q <= 1'b0;
			faddr_o   <= 2'b00;
		end
		else
		begin
			pkt_end_q <= pop_o & pkt_last_i;
			if (pkt_end_q)
			begin
				faddr_o <= faddr_o ^ 2'b01;
			end
		end
	end

endmodule

//--- src/usb_word_out.sv
`include "usb_stream_defines.svh"

module usb_word_out
	import usb_stream_pkg::*;
(
	input  logic       hdmit_halfclk,
	input  logic       reset,
	input  logic       word_issue_i,
	input  logic       hdr_sel_i,
	input  logic [1:0] hdr_idx_i,
	input  logic       frame_last_pkt_i,
	input  logic       pkt_last_i,
	input  usb_word_t  fifo_data_i,
	output usb_word_t  fdata_o,
	output logic       slwr_o,
	output logic       pktend_o
);

	usb_word_t hdr_word;
	usb_word_t word_nxt;

	// video payload header table
	always_comb
	begin
		case (hdr_idx_i)
			2'd0:    hdr_word = frame_last_pkt_i ? `USB_HDR_EOF : `USB_HDR_NORMAL;
			default: hdr_word = '0;   // words 1 and 2 carry no timestamp
		endcase
	end

	assign word_nxt = hdr_sel_i ? hdr_word : fifo_data_i;

	// --------------------------------------------------
	// bus registers, strobes active low
	// --------------------------------------------------
	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			fdata_o  <= '0;
			slwr_o   <= 1'b1;
			pktend_o <= 1'b1;
		end
		else
		begin
			slwr_o   <= ~word_issue_i;
			pktend_o <= ~(word_issue_i & pkt_last_i & frame_last_pkt_i);
			if (word_issue_i)
			begin
				fdata_o <= word_nxt;
			end
		end
	end

endmodule

//--- src/usb_stream_top.sv
`include "usb_stream_defines.svh"

module usb_stream_top
	import usb_stream_pkg::*;
(
	input  logic       hdmit_halfclk,
	input  logic       reset,
	// pixel source
	input  logic       pix_de_i,
	input  pix_t       pix_data_i,
	output logic       pix_ready_o,
	// peripheral slave fifo bus
	input  logic       flaga_i,
	input  cnt_t       pkt_count_i,
	input  cnt_t       last_words_i,
	output usb_word_t  fdata_o,
	output logic [1:0] faddr_o,
	output logic       slwr_o,
	output logic       pktend_o
);

	logic       fifo_wr_en;
	usb_word_t  fifo_wr_data;
	usb_word_t  fifo_rd_data;
	logic       fifo_empty;
	logic       fifo_full;
	logic       fifo_afull;

	logic       word_issue;
	logic       hdr_sel;
	logic       pop;
	logic       gap_run;
	logic       hdr_done;
	logic       pkt_last;
	logic       frame_last_pkt;
	logic       gap_done;
	logic [1:0] hdr_idx;

	pixel_packer u_pixel_packer (
		.hdmit_halfclk (hdmit_halfclk),
		.reset         (reset),
		.pix_de_i      (pix_de_i),
		.pix_data_i    (pix_data_i),
		.fifo_full_i   (fifo_full),
		.fifo_afull_i  (fifo_afull),
		.pix_ready_o   (pix_ready_o),
		.wr_en_o       (fifo_wr_en),
		.wr_data_o     (fifo_wr_data)
	);

	stream_fifo #(
		.AW (`USB_FIFO_AW)
	) u_stream_fifo (
		.hdmit_halfclk (hdmit_halfclk),
		.reset         (reset),
		.wr_en_i       (fifo_wr_en),
		.wr_data_i     (fifo_wr_data),
		.rd_en_i       (pop),
		.rd_data_o     (fifo_rd_data),
		.empty_o       (fifo_empty),
		.full_o        (fifo_full),
		.afull_o       (fifo_afull)
	);

	packet_counter u_packet_counter (
		.hdmit_halfclk    (hdmit_halfclk),
		.reset            (reset),
		.word_issue_i     (word_issue),
		.gap_run_i        (gap_run),
		.pkt_count_i      (pkt_count_i),
		.last_words_i     (last_words_i),
		.hdr_done_o       (hdr_done),
		.pkt_last_o       (pkt_last),
		.frame_last_pkt_o (frame_last_pkt),
		.gap_done_o       (gap_done),
		.hdr_idx_o        (hdr_idx)
	);

	usb_master_fsm u_usb_master_fsm (
		.hdmit_halfclk (hdmit_halfclk),
		.reset         (reset),
		.flaga_i       (flaga_i),
		.fifo_empty_i  (fifo_empty),
		.hdr_done_i    (hdr_done),
		.pkt_last_i    (pkt_last),
		.gap_done_i    (gap_done),
		.word_issue_o  (word_issue),
		.hdr_sel_o     (hdr_sel),
		.pop_o         (pop),
		.gap_run_o     (gap_run),
		.faddr_o       (faddr_o)
	);

	usb_word_out u_usb_word_out (
		.hdmit_halfclk    (hdmit_halfclk),
		.reset            (reset),
		.word_issue_i     (word_issue),
		.hdr_sel_i        (hdr_sel),
		.hdr_idx_i        (hdr_idx),
		.frame_last_pkt_i (frame_last_pkt),
		.pkt_last_i       (pkt_last),
		.fifo_data_i      (fifo_rd_data),
		.fdata_o          (fdata_o),
		.slwr_o           (slwr_o),
		.pktend_o         (pktend_o)
	);

endmodule

//--- tb/usb_stream_properties.sv
`include "usb_stream_defines.svh"

module usb_stream_properties (
	input logic hdmit_halfclk,
	input logic reset,
	input logic flaga_i,
	input logic word_issue,
	input logic pkt_last,
	input logic slwr_o,
	input logic pktend_o
);

	logic       last_on_bus;   // last word of a packet is on the bus
	logic [3:0] idle_run;      // write strobe high cycles since that word

	always_ff @(posedge hdmit_halfclk or posedge reset)
	begin
		if (reset)
		begin
			last_on_bus <= 1'b0;
			idle_run    <= 4'd15;
		end
		else
		begin
			last_on_bus <= word_issue & pkt_last;
			if (last_on_bus)
				idle_run <= 4'd0;
			else if (slwr_o && idle_run != 4'd15)
				idle_run <= idle_run + 4'd1;   // saturates
		end
	end

	// --------------------------------------------------
	// bus rules
	// --------------------------------------------------
	pktend_with_write: assert property (@(posedge hdmit_halfclk) disable iff (reset)
		!pktend_o |-> !slwr_o)
		else $error("packet end strobe low without the write strobe");

	flag_stalls_write: assert property (@(posedge hdmit_halfclk) disable iff (reset)
		!flaga_i |=> slwr_o)
		else $error("write strobe low in the cycle after the ready flag was low");

	gap_after_packet: assert property (@(posedge hdmit_halfclk) disable iff (reset)
		!slwr_o |-> idle_run >= 4'(`USB_GAP_CYCLES + 1))
		else $error("next packet started before the idle gap had passed");

endmodule

bind usb_stream_top usb_stream_properties usb_stream_properties_i (
	.hdmit_halfclk (hdmit_halfclk),
	.reset         (reset),
	.flaga_i       (flaga_i),
	.word_issue    (word_issue),
	.pkt_last      (pkt_last),
	.slwr_o        (slwr_o),
	.pktend_o      (pktend_o)
);

//--- tb/usb_stream_tb.sv
`include "usb_stream_defines.svh"

module usb_stream_tb
	import usb_stream_pkg::*;
();

	localparam int CLK_PERIOD      = 40;
	localparam int FRAMES          = 2;
	localparam int PKT_COUNT       = 2;
	localparam int LAST_WORDS      = 100;
	localparam int FULL_WORDS      = int'(`USB_PKT_WORDS);
	localparam int HDR_WORDS       = int'(`USB_HDR_WORDS);
	localparam int GAP_MIN         = int'(`USB_GAP_CYCLES) + 1;
	localparam int FIFO_DEPTH      = 2 ** `USB_FIFO_AW;
	localparam int PAY_FULL        = FULL_WORDS - HDR_WORDS;
	localparam int PAY_FRAME       = (PKT_COUNT - 1) * PAY_FULL + LAST_WORDS - HDR_WORDS;
	localparam int TOTAL_WORDS     = FRAMES * ((PKT_COUNT - 1) * FULL_WORDS + LAST_WORDS);
	localparam int TOTAL_PIX       = 2 * FRAMES * PAY_FRAME;
	localparam int STALL_START     = 200;    // cycles after reset
	localparam int STALL_CYCLES    = 2500;   // long enough to fill the FIFO
	localparam int WATCHDOG_CYCLES = 4 * TOTAL_WORDS + STALL_CYCLES + 2000;

	logic       hdmit_halfclk = 1'b0;
	logic       reset;
	logic       pix_de_i;
	pix_t       pix_data_i;
	logic       pix_ready_o;
	logic       flaga_i;
	cnt_t       pkt_count_i;
	cnt_t       last_words_i;
	usb_word_t  fdata_o;
	logic [1:0] faddr_o;
	logic       slwr_o;
	logic       pktend_o;

	logic pix_start;
	logic flaga_q;      // flag as seen by the issuing edge
	logic bus_live;
	logic pix_sent_q;
	int   seed = 64;

	// comparator state
	int   errors     = 0;
	int   words_seen = 0;
	int   frame      = 0;
	int   pkt        = 0;
	int   word       = 0;
	int   idle_cnt   = 0;
	int   pix_taken  = 0;   // pixels accepted by the DUT
	int   pairs_out  = 0;   // payload words seen on the bus
	logic gap_armed  = 1'b0;
	logic socket     = 1'b0;

	usb_stream_top usb_stream_top_i (
		.hdmit_halfclk (hdmit_halfclk),
		.reset         (reset),
		.pix_de_i      (pix_de_i),
		.pix_data_i    (pix_data_i),
		.pix_ready_o   (pix_ready_o),
		.flaga_i       (flaga_i),
		.pkt_count_i   (pkt_count_i),
		.last_words_i  (last_words_i),
		.fdata_o       (fdata_o),
		.faddr_o       (faddr_o),
		.slwr_o        (slwr_o),
		.pktend_o      (pktend_o)
	);

	always #(CLK_PERIOD / 2) hdmit_halfclk = ~hdmit_halfclk;

	// counter pattern of the pixel source
	function automatic pix_t pixel_value(input int k);
		return pix_t'(k);
	endfunction

	// --------------------------------------------------
	// reference model of the bus word sequence
	// --------------------------------------------------
	function automatic usb_word_t expected_word(input int f, input int p, input int w);
		int pair;
		pair = f * PAY_FRAME + p * PAY_FULL + (w - HDR_WORDS);
		if (w == 0)
			return (p == PKT_COUNT - 1) ? `USB_HDR_EOF : `USB_HDR_NORMAL;
		else if (w < HDR_WORDS)
			return '0;
		return {pixel_value(2 * pair + 1), pixel_value(2 * pair)};   // first pixel low
	endfunction

	// source may send unless the FIFO has no room left for the pair
	function automatic logic source_ready(input int taken, input int popped);
		int held;
		held = taken / 2 - popped;
		if (taken % 2 == 1)
			return held < FIFO_DEPTH - 1;
		return held < FIFO_DEPTH;
	endfunction

	task automatic check_word();
		int         plen;
		logic       last;
		usb_word_t  exp_word;
		logic       exp_pktend;
		logic [1:0] exp_faddr;
		string      name;
		words_seen++;
		assert (pix_sent_q) else
		begin
			errors++;
			$display("bus write seen before any pixel was sent");
		end
		assert (flaga_q) else
		begin
			errors++;
			$display("write strobe low in the cycle after flaga_i was low");
		end
		assert (frame < FRAMES) else
		begin
			errors++;
			$display("unexpected bus write after the last frame");
		end
		if (frame < FRAMES)
		begin
			plen       = (pkt == PKT_COUNT - 1) ? LAST_WORDS : FULL_WORDS;
			last       = (word == plen - 1);
			exp_word   = expected_word(frame, pkt, word);
			exp_pktend = ~(last & (pkt == PKT_COUNT - 1));
			exp_faddr  = {1'b0, socket};   // one socket per packet
			name       = (word < HDR_WORDS) ? "header" : "payload";
			if (word >= HDR_WORDS)
				pairs_out++;
			if (word == 0 && gap_armed)
			begin
				assert (idle_cnt >= GAP_MIN) else
				begin
					errors++;
					$display("[ERROR] packet gap f%0d p%0d: expected >= %0d, actual %0d",
						frame, pkt, GAP_MIN, idle_cnt);
				end
			end
			assert (fdata_o == exp_word) else
			begin
				errors++;
				$display("[ERROR] %s f%0d p%0d w%0d: expected %h, actual %h",
					name, frame, pkt, word, exp_word, fdata_o);
			end
			assert (pktend_o == exp_pktend) else
			begin
				errors++;
				$display("[ERROR] pktend f%0d p%0d w%0d: expected %b, actual %b",
					frame, pkt, word, exp_pktend, pktend_o);
			end
			assert (faddr_o == exp_faddr) else
			begin
				errors++;
				$display("[ERROR] faddr f%0d p%0d w%0d: expected %0d, actual %0d",
					frame, pkt, word, exp_faddr, faddr_o);
			end
			if (last)
			begin
				word      = 0;
				socket    = ~socket;
				idle_cnt  = 0;
				gap_armed = 1'b1;
				if (pkt == PKT_COUNT - 1)
				begin
					pkt = 0;
					frame++;
				end
				else
					pkt++;
			end
			else
				word++;
		end
	endtask

	always @(posedge hdmit_halfclk)
	begin
		flaga_q    <= flaga_i;
		bus_live   <= ~reset;
		pix_sent_q <= pix_start;
		if (!reset && pix_de_i && pix_ready_o)
			pix_taken <= pix_taken + 1;
	end

	// bus outputs are stable at the falling edge
	always @(negedge hdmit_halfclk)
	begin
		if (bus_live)
		begin
			if (!slwr_o)
				check_word();
			else
			begin
				idle_cnt++;
				assert (pktend_o) else
				begin
					errors++;
					$display("pktend_o low while slwr_o is high");
				end
				if (!pix_sent_q)
				begin
					assert (faddr_o == 2'b00) else
					begin
						errors++;
						$display("faddr_o not 0 while the bus is idle after reset");
					end
				end
			end
			assert (pix_ready_o == source_ready(pix_taken, pairs_out)) else
			begin
				errors++;
				$display("[ERROR] pix_ready after %0d pixels: expected %b, actual %b",
					pix_taken, source_ready(pix_taken, pairs_out), pix_ready_o);
			end
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial
	begin
		int   pix_idx;
		logic ready_prev;
		pix_de_i   = 1'b0;
		pix_data_i = '0;
		pix_idx    = 0;
		ready_prev = 1'b0;
		wait (pix_start);
		while (pix_idx < TOTAL_PIX)
		begin
			@(negedge hdmit_halfclk);
			if (pix_de_i && ready_prev)
				pix_idx++;   // taken at the last rising edge
			if (pix_idx < TOTAL_PIX)
			begin
				pix_de_i   = 1'b1;
				pix_data_i = pixel_value(pix_idx);
			end
			else
				pix_de_i = 1'b0;
			ready_prev = pix_ready_o;
		end
	end

	initial
	begin
		int cyc;
		flaga_i = 1'b0;
		cyc     = 0;
		wait (!reset);
		forever
		begin
			@(negedge hdmit_halfclk);
			cyc++;
			if (cyc > STALL_START && cyc <= STALL_START + STALL_CYCLES)
				flaga_i = 1'b0;   // peripheral busy, source gets held off
			else
				flaga_i = (($random(seed) & 3) != 0);   // ready three times in four
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog timeout, %0d of %0d words seen", words_seen, TOTAL_WORDS);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		reset        = 1'b1;
		pix_start    = 1'b0;
		pkt_count_i  = cnt_t'(PKT_COUNT);
		last_words_i = cnt_t'(LAST_WORDS);
		repeat (10) @(posedge hdmit_halfclk);
		@(negedge hdmit_halfclk);
		reset = 1'b0;
		repeat (8) @(negedge hdmit_halfclk);   // bus must stay idle
		pix_start = 1'b1;
		wait (frame == FRAMES);
		repeat (40) @(negedge hdmit_halfclk);  // catch stray words
		$display("errors: %0d, words checked: %0d of %0d", errors, words_seen, TOTAL_WORDS);
		if (errors == 0 && words_seen == TOTAL_WORDS)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- usb_stream.f
+incdir+src
src/usb_stream_pkg.sv
src/pixel_packer.sv
src/stream_fifo.sv
src/packet_counter.sv
src/usb_master_fsm.sv
src/usb_word_out.sv
src/usb_stream_top.sv
tb/usb_stream_properties.sv
tb/usb_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f usb_stream.f --top-module usb_stream_tb \
	-Mdir "$OBJ" -o usb_stream_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/usb_stream_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
